//--- Makefile
TOP = rv_core_tb

lint:
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: lint sim clean

//--- all.f
+incdir+hdl
+incdir+verif
hdl/rv_pkg.sv
hdl/rv_ctrl_if.sv
hdl/control_decoder.sv
hdl/imm_generator.sv
hdl/register_file.sv
hdl/alu.sv
hdl/execute_datapath.sv
hdl/rv_core.sv
verif/rv_core_tb.sv

//--- hdl/alu.sv
`include "rv_settings.svh"

module alu (
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    input  rv_pkg::alu_op_t     op,
    output logic [`RV_XLEN-1:0] result,
    output logic                zero
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ADD:  result = a + b;
            SUB:  result = a - b;
            AND:  result = a & b;
            OR:   result = a | b;
            XOR:  result = a ^ b;
            SLT:  result = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            SLTU: result = {{(`RV_XLEN-1){1'b0}}, a < b};
            SLL:  result = a << shamt;
            SRL:  result = a >> shamt;
            SRA:  result = $unsigned($signed(a) >>> shamt); // sign fill
            default: result = '0;
        endcase
    end

    // used by beq after a subtract
    assign zero = (result == '0);

endmodule

//--- hdl/control_decoder.sv
`include "rv_settings.svh"

module control_decoder (
    input logic [`RV_XLEN-1:0] instr,
    rv_ctrl_if.decoder         ctrl
);
    import rv_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];

    ////////////////////////////////////////
    // control levels
    ////////////////////////////////////////
    always_comb begin
        ctrl.reg_write  = 1'b0;
        ctrl.mem_to_reg = 1'b0;
        ctrl.mem_write  = 1'b0;
        ctrl.alu_src    = 1'b0;
        ctrl.branch     = 1'b0;
        ctrl.a_src      = A_REG;
        case (opcode)
            OP: ctrl.reg_write = 1'b1;
            OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            LOAD: begin
                ctrl.reg_write  = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1; // address = rs1 + s-imm
            end
            BRANCH: ctrl.branch = 1'b1; // compare rs1 with rs2
            LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.a_src     = A_ZERO;
            end
            AUIPC: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.a_src     = A_PC;
            end
            default: ; // unsupported opcodes leave everything inactive
        endcase
    end

    // bit 30 only matters for sub and sra/srai
    always_comb begin
        ctrl.alu_op = ADD;
        if (opcode == OP || opcode == OP_IMM) begin
            case (funct3)
                3'b000:  ctrl.alu_op = (opcode == OP && instr[30]) ? SUB : ADD;
                3'b001:  ctrl.alu_op = SLL;
                3'b010:  ctrl.alu_op = SLT;
                3'b011:  ctrl.alu_op = SLTU;
                3'b100:  ctrl.alu_op = XOR;
                3'b101:  ctrl.alu_op = instr[30] ? SRA : SRL;
                3'b110:  ctrl.alu_op = OR;
                default: ctrl.alu_op = AND;
            endcase
        end else if (opcode == BRANCH) begin
            ctrl.alu_op = SUB; // zero flag gives equality
        end
    end

endmodule

//--- hdl/execute_datapath.sv
`include "rv_settings.svh"

module execute_datapath (
    input  logic                     CLK,
    input  logic                     RESET_N,
    input  logic [`RV_XLEN-1:0]       instr,
    input  logic [`RV_XLEN-1:0]       imm,
    rv_ctrl_if.datapath              ctrl,
    input  logic [`RV_XLEN-1:0]       q_ram,
    output logic [`RV_ADDR_WIDTH-1:0] pc,
    output logic [`RV_XLEN-1:0]       alu_result,
    output logic [`RV_XLEN-1:0]       store_data
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0]       rs1_data;
    logic [`RV_XLEN-1:0]       rs2_data;
    logic [`RV_XLEN-1:0]       op_a;
    logic [`RV_XLEN-1:0]       op_b;
    logic [`RV_XLEN-1:0]       wb_data;
    logic                     alu_zero;
    logic                     branch_taken;
    logic [`RV_ADDR_WIDTH-1:0] pc_next;

    register_file u_regs (
        .CLK     (CLK),
        .RESET_N (RESET_N),
        .rs1     (instr[19:15]),
        .rs2     (instr[24:20]),
        .rd      (instr[11:7]),
        .wr_data (wb_data),
        .wr_en   (ctrl.reg_write),
        .rd1     (rs1_data),
        .rd2     (rs2_data)
    );

    ////////////////////////////////////////
    // operand select and alu
    ////////////////////////////////////////
    always_comb begin
        case (ctrl.a_src)
            A_PC:    op_a = {{(`RV_XLEN-`RV_ADDR_WIDTH){1'b0}}, pc}; // word pc
            A_ZERO:  op_a = '0;
            default: op_a = rs1_data;
        endcase
    end

    assign op_b = ctrl.alu_src ? imm : rs2_data;

    alu u_alu (
        .a      (op_a),
        .b      (op_b),
        .op     (ctrl.alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    assign wb_data    = ctrl.mem_to_reg ? q_ram : alu_result;
    assign store_data = rs2_data;

    // program counter counts words, so the byte offset is divided by four
    assign branch_taken = ctrl.branch & alu_zero;
    assign pc_next      = branch_taken ? pc + imm[`RV_ADDR_WIDTH+1:2]
                                       : pc + `RV_ADDR_WIDTH'(1);

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) pc <= '0;
        else          pc <= pc_next;
    end

    a_branch_no_wb: assert property (@(posedge CLK) disable iff (!RESET_N)
        branch_taken |-> !ctrl.reg_write)
        else $error("taken branch with register write");

endmodule

//--- hdl/imm_generator.sv
`include "rv_settings.svh"

module imm_generator (
    input  logic [`RV_XLEN-1:0] instr,
    output logic [`RV_XLEN-1:0] imm
);
    import rv_pkg::*;

    imm_t fmt;
    logic has_imm; // low for r-type and unknown opcodes

    ////////////////////////////////////////
    // format select
    ////////////////////////////////////////
    always_comb begin
        fmt     = IMM_I;
        has_imm = 1'b1;
        case (opcode_t'(instr[6:0]))
            OP_IMM, LOAD: fmt = IMM_I;
            STORE:        fmt = IMM_S;
            BRANCH:       fmt = IMM_B;
            LUI, AUIPC:   fmt = IMM_U;
            default:      has_imm = 1'b0;
        endcase
    end

    // assemble and sign-extend
    always_comb begin
        imm = '0;
        if (has_imm) begin
            case (fmt)
                IMM_I: imm = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
                IMM_S: imm = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
                IMM_B: imm = {{(`RV_XLEN-13){instr[31]}}, instr[31], instr[7],
                              instr[30:25], instr[11:8], 1'b0};
                IMM_U: imm = {instr[31:12], 12'b0}; // 20 bits in the upper positions
                default: imm = '0;
            endcase
        end
    end

endmodule

//--- hdl/register_file.sv
`include "rv_settings.svh"

module register_file (
    input  logic               CLK,
    input  logic               RESET_N,
    input  logic [4:0]         rs1,
    input  logic [4:0]         rs2,
    input  logic [4:0]         rd,
    input  logic [`RV_XLEN-1:0] wr_data,
    input  logic               wr_en,
    output logic [`RV_XLEN-1:0] rd1,
    output logic [`RV_XLEN-1:0] rd2
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    // write at the edge that ends the instruction
    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && rd != 5'd0) begin // x0 stays zero
            regs[rd] <= wr_data;
        end
    end

    // combinational reads
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////
    a_x0_zero: assert property (@(posedge CLK) regs[0] == '0)
        else $error("x0 holds a nonzero value");

endmodule

//--- hdl/rv_core.sv
`include "rv_settings.svh"

module rv_core (
    input  logic                     CLK,
    input  logic                     RESET_N,
    input  logic [`RV_XLEN-1:0]       q_rom,    // fetched instruction
    input  logic [`RV_XLEN-1:0]       q_ram,    // load data
    output logic [`RV_ADDR_WIDTH-1:0] addr_rom,
    output logic [`RV_ADDR_WIDTH-1:0] addr_ram,
    output logic [`RV_XLEN-1:0]       q_w,      // store data
    output logic                     enable_w
);

    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] alu_result;

    rv_ctrl_if ctrl_bus ();

    ////////////////////////////////////////
    // decode, side by side
    ////////////////////////////////////////
    control_decoder u_decoder (
        .instr (q_rom),
        .ctrl  (ctrl_bus.decoder)
    );

    imm_generator u_imm_gen (
        .instr (q_rom),
        .imm   (imm)
    );

    // execute and write back
    execute_datapath u_datapath (
        .CLK        (CLK),
        .RESET_N    (RESET_N),
        .instr      (q_rom),
        .imm        (imm),
        .ctrl       (ctrl_bus.datapath),
        .q_ram      (q_ram),
        .pc         (addr_rom),
        .alu_result (alu_result),
        .store_data (q_w)
    );

    assign addr_ram = alu_result[`RV_ADDR_WIDTH-1:0]; // word address into ram
    assign enable_w = ctrl_bus.mem_write;

endmodule

//--- hdl/rv_ctrl_if.sv
interface rv_ctrl_if;
    import rv_pkg::*;

    logic    reg_write;  // write rd at end of instruction
    logic    mem_to_reg; // write-back from data ram
    logic    mem_write;  // store strobe
    logic    alu_src;    // second operand is the immediate
    logic    branch;     // beq
    a_src_t  a_src;
    alu_op_t alu_op;

    modport decoder (
        output reg_write, mem_to_reg, mem_write, alu_src,
        output branch, a_src, alu_op
    );

    // all levels are combinational from the fetched instruction
    modport datapath (
        input reg_write, mem_to_reg, mem_write, alu_src,
        input branch, a_src, alu_op
    );

endinterface

//--- hdl/rv_pkg.sv
package rv_pkg;

    ////////////////////////////////////////
    // major opcodes, instr[6:0]
    ////////////////////////////////////////
    typedef enum logic [6:0] {
        OP     = 7'b0110011, // register-register alu
        OP_IMM = 7'b0010011, // register-immediate alu
        LOAD   = 7'b0000011, // lw only
        STORE  = 7'b0100011, // sw only
        BRANCH = 7'b1100011, // beq only
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_t;

    // alu functions
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        SLT  = 4'd5,
        SLTU = 4'd6,
        SLL  = 4'd7,
        SRL  = 4'd8,
        SRA  = 4'd9
    } alu_op_t;

    // first alu operand select
    typedef enum logic [1:0] {
        A_PC   = 2'd0, // auipc
        A_ZERO = 2'd1, // lui
        A_REG  = 2'd2  // rs1
    } a_src_t;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3
    } imm_t;

endpackage

//--- hdl/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// datapath width
`define RV_XLEN 32

// word address width of instruction ROM and data RAM
`define RV_ADDR_WIDTH 10

`define RV_REG_COUNT 32 // architectural registers x0..x31

`endif

//--- verif/rv_core_tests.svh
`ifndef RV_CORE_TESTS_SVH
`define RV_CORE_TESTS_SVH

////////////////////////////////////////
// run control
////////////////////////////////////////
task automatic reset_core();
    @(posedge CLK);
    RESET_N <= 1'b0;
    @(negedge CLK);
endtask

task automatic release_core();
    repeat (2) @(posedge CLK); // reset held for two cycles
    RESET_N <= 1'b1;
    @(negedge CLK);
endtask

// x1 = a, x2 = b built from lui plus addi at words 0..3
task automatic load_operands(logic [31:0] a, logic [31:0] b);
    logic [31:0] ah;
    logic [31:0] bh;
    ah = a + 32'h800; // addi sign-extends the low part
    bh = b + 32'h800;
    rom[0] = enc_u(ah[31:12], 5'd1, LUI);
    rom[1] = enc_i(a[11:0], 5'd1, 3'b000, 5'd1, OP_IMM);
    rom[2] = enc_u(bh[31:12], 5'd2, LUI);
    rom[3] = enc_i(b[11:0], 5'd2, 3'b000, 5'd2, OP_IMM);
endtask

task automatic step_to_pc4();
    for (int i = 0; i < 4; i++) begin
        check_addr("addr_rom", addr_rom, 10'(i));
        check_bit("enable_w", enable_w, 1'b0);
        @(negedge CLK);
    end
endtask

// instr at word 4, then sw src, 12(x1) at word 5
task automatic run_store_check(logic [31:0] a, logic [31:0] b, logic [31:0] instr,
                               logic [4:0] src, logic [31:0] exp);
    reset_core();
    load_operands(a, b);
    rom[4] = instr;
    rom[5] = enc_s(12'd12, src, 5'd1);
    release_core();
    step_to_pc4();
    check_bit("enable_w", enable_w, 1'b0);
    @(negedge CLK);
    check_addr("addr_rom", addr_rom, 10'd5);
    check_bit("enable_w", enable_w, 1'b1);
    check_addr("addr_ram", addr_ram, a[9:0] + 10'd12);
    check_data("q_w", q_w, exp);
    @(posedge CLK); // let the store land in ram
endtask

task automatic check_i(logic [31:0] a, logic [11:0] imm, logic [2:0] f3, logic [31:0] exp);
    run_store_check(a, 32'd0, enc_i(imm, 5'd1, f3, 5'd3, OP_IMM), 5'd3, exp);
endtask

task automatic check_r(logic [31:0] a, logic [31:0] b, logic [6:0] f7, logic [2:0] f3,
                       logic [31:0] exp);
    run_store_check(a, b, enc_r(f7, 5'd2, 5'd1, f3, 5'd3), 5'd3, exp);
endtask

////////////////////////////////////////
// directed tests
////////////////////////////////////////
task automatic test_sequencing();
    reset_core();
    for (int i = 0; i < 8; i++) rom[i] = enc_i(12'(i + 1), 5'd1, 3'b000, 5'd1, OP_IMM);
    release_core();
    for (int i = 0; i < 8; i++) begin
        check_addr("addr_rom", addr_rom, 10'(i)); // one word per cycle
        check_bit("enable_w", enable_w, 1'b0);
        @(negedge CLK);
    end
endtask

task automatic test_imm_ops();
    logic [31:0] a;
    logic [31:0] r;
    logic [31:0] se;
    logic [4:0]  sh;
    for (int n = 0; n < 2; n++) begin
        a  = rand_bits(32);
        r  = rand_bits(12);
        se = {{20{r[11]}}, r[11:0]};
        r  = rand_bits(5);
        sh = r[4:0];
        check_i(a, se[11:0], 3'b000, a + se);
        check_i(a, se[11:0], 3'b100, a ^ se);
        check_i(a, se[11:0], 3'b110, a | se);
        check_i(a, se[11:0], 3'b111, a & se);
        check_i(a, se[11:0], 3'b010, {31'd0, $signed(a) < $signed(se)});
        check_i(a, se[11:0], 3'b011, {31'd0, a < se});
        check_i(a, {7'b0000000, sh}, 3'b001, a << sh);
        check_i(a, {7'b0000000, sh}, 3'b101, a >> sh);
        check_i(a, {7'b0100000, sh}, 3'b101, $signed(a) >>> sh); // srai
    end
endtask

task automatic test_reg_ops();
    logic [31:0] a;
    logic [31:0] b;
    for (int n = 0; n < 2; n++) begin
        a = rand_bits(32);
        b = rand_bits(32);
        check_r(a, b, 7'h00, 3'b000, a + b);
        check_r(a, b, 7'h20, 3'b000, a - b);
        check_r(a, b, 7'h00, 3'b111, a & b);
        check_r(a, b, 7'h00, 3'b110, a | b);
        check_r(a, b, 7'h00, 3'b100, a ^ b);
        check_r(a, b, 7'h00, 3'b010, {31'd0, $signed(a) < $signed(b)});
        check_r(a, b, 7'h00, 3'b011, {31'd0, a < b});
        check_r(a, b, 7'h00, 3'b001, a << b[4:0]);
        check_r(a, b, 7'h00, 3'b101, a >> b[4:0]);
        check_r(a, b, 7'h20, 3'b101, $signed(a) >>> b[4:0]);
    end
    // add x0, x1, x2 then sw x0
    run_store_check(a, b, enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0), 5'd0, 32'd0);
endtask

task automatic test_load();
    logic [31:0] a;
    logic [31:0] r;
    logic [31:0] se;
    logic [31:0] w;
    for (int n = 0; n < 3; n++) begin
        a  = rand_bits(32);
        r  = rand_bits(12);
        se = {{20{r[11]}}, r[11:0]};
        w  = rand_bits(32);
        ram[a[9:0] + se[9:0]] = w; // word at rs1 + i-imm
        run_store_check(a, 32'd0, enc_i(se[11:0], 5'd1, 3'b010, 5'd3, LOAD), 5'd3, w);
    end
endtask

task automatic run_branch(logic [31:0] a, logic [31:0] b, logic [12:0] off,
                          logic [9:0] exp_pc);
    reset_core();
    load_operands(a, b);
    rom[4] = enc_b(off, 5'd2, 5'd1);
    rom[5] = 32'h00000013;
    release_core();
    step_to_pc4();
    @(negedge CLK);
    check_addr("addr_rom", addr_rom, exp_pc);
endtask

task automatic test_branch();
    logic [31:0] a;
    a = rand_bits(32);
    run_branch(a, a, 13'd20, 10'd9);          // 4 + 20/4
    run_branch(a, a, 13'h1FF4, 10'd1);        // 4 - 12/4
    run_branch(a, a ^ 32'd1, 13'd20, 10'd5);  // not taken
    run_branch(a, ~a, 13'h1FF4, 10'd5);
endtask

task automatic test_upper();
    logic [31:0] r;
    r = rand_bits(20);
    run_store_check(32'd0, 32'd0, enc_u(r[19:0], 5'd3, LUI), 5'd3, {r[19:0], 12'd0});
    // auipc sits at word 4
    run_store_check(32'd0, 32'd0, enc_u(r[19:0], 5'd3, AUIPC), 5'd3, {r[19:0], 12'd0} + 32'd4);
endtask

`endif

//--- verif/rv_core_tb.sv
`include "rv_settings.svh"

module rv_core_tb;
    import rv_pkg::*;

    logic                      CLK;
    logic                      RESET_N;
    logic [`RV_XLEN-1:0]       q_rom;
    logic [`RV_XLEN-1:0]       q_ram;
    logic [`RV_ADDR_WIDTH-1:0] addr_rom;
    logic [`RV_ADDR_WIDTH-1:0] addr_ram;
    logic [`RV_XLEN-1:0]       q_w;
    logic                      enable_w;

    logic [`RV_XLEN-1:0] rom [1 << `RV_ADDR_WIDTH]; // instruction memory
    logic [`RV_XLEN-1:0] ram [1 << `RV_ADDR_WIDTH]; // data memory
    logic [31:0]         lfsr_state;
    int                  cycles = 0;

    rv_core UUT (.*);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    // both memories answer combinationally
    assign q_rom = rom[addr_rom];
    assign q_ram = ram[addr_ram];

    always @(posedge CLK) begin
        if (enable_w) ram[addr_ram] <= q_w;
    end

    ////////////////////////////////////////
    // timeout
    ////////////////////////////////////////
    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= 1000) fail_run("timeout, tests still running after 1000 cycles");
    end

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped");
    endtask

    task automatic check_addr(string name, logic [`RV_ADDR_WIDTH-1:0] got,
                              logic [`RV_ADDR_WIDTH-1:0] exp);
        if (got !== exp) fail_run($sformatf("error %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_data(string name, logic [`RV_XLEN-1:0] got, logic [`RV_XLEN-1:0] exp);
        if (got !== exp) fail_run($sformatf("error %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) fail_run($sformatf("error %s got %h expected %h", name, got, exp));
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
        end
        return r;
    endfunction

    ////////////////////////////////////////
    // instruction encoders
    ////////////////////////////////////////
    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                          logic [4:0] rd, opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, opcode_t op);
        return {imm, rd, op};
    endfunction

    `include "rv_core_tests.svh"

    initial begin
        RESET_N    = 1'b0;
        lfsr_state = 32'd89;
        for (int i = 0; i < (1 << `RV_ADDR_WIDTH); i++) begin
            rom[i] = 32'h00000013; // nop
            ram[i] = 32'hA5A50000 ^ 32'(i);
        end
        test_sequencing();
        test_imm_ops();
        test_reg_ops();
        test_load();
        test_branch();
        test_upper();
        $display("PASS: all tests");
        $finish;
    end

endmodule
